/* verilog/lwc_pkg.sv */
// LWC framer shared definitions
`default_nettype none

package lwc_pkg;

    localparam int lwc_word_w = 32;
    localparam int lwc_seg_len_w = 16;

    typedef logic [lwc_word_w-1:0] lwc_word_t;
    typedef logic [lwc_seg_len_w-1:0] lwc_seg_len_t;
    // Valid bytes in a word, 0 to 4
    typedef logic [2:0] lwc_size_t;

    localparam int lwc_bytes_per_word = 4;

    // Segment header flag positions
    localparam int lwc_eot_bit = 25;
    localparam int lwc_last_bit = 24;

    // Output header types and status
    localparam logic [3:0] lwc_hdr_enc_code = 4'b0101;
    localparam logic [3:0] lwc_hdr_dec_code = 4'b0100;
    localparam logic [3:0] lwc_status_ok_code = 4'b1110;

    typedef enum logic [3:0] {
        op_enc = 4'b0010,
        op_dec = 4'b0011
    } lwc_opcode_e;

    // DO word source
    typedef enum logic [1:0] {
        sel_none,
        sel_out_hdr,
        sel_data,
        sel_status
    } lwc_do_sel_e;

endpackage

`default_nettype wire

/* verilog/lwc_pdi_buffer.sv */
// PDI input buffer
`timescale 1ns/100ps
`default_nettype none

module lwc_pdi_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  lwc_pkg::lwc_word_t pdi_data,
    input  logic              pdi_valid,
    output logic              pdi_ready,
    output lwc_pkg::lwc_word_t buf_data,
    output logic              buf_valid,
    input  logic              buf_pop
);

    logic load;

    // Accept while empty or while the held word leaves
    assign pdi_ready = !buf_valid || buf_pop;
    assign load = pdi_valid && pdi_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;
        end else if (load) begin
            buf_valid <= 1'b1;
        end else if (buf_pop) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            buf_data <= pdi_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/lwc_segment_counter.sv */
// Segment length counter
`timescale 1ns/100ps
`default_nettype none

module lwc_segment_counter (
    input  logic              clk,
    input  logic              arst_n,
    input  lwc_pkg::lwc_word_t buf_data,
    input  logic              cnt_load,
    input  logic              cnt_step,
    output logic              seg_empty,
    output logic              word_last,
    output lwc_pkg::lwc_size_t word_size
);

    import lwc_pkg::*;

    lwc_seg_len_t remaining;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            remaining <= '0;
        end else if (cnt_load) begin
            remaining <= buf_data[lwc_seg_len_w-1:0];
        end else if (cnt_step) begin
            if (word_last) begin
                remaining <= '0;
            end else begin
                remaining <= remaining - lwc_seg_len_t'(lwc_bytes_per_word);
            end
        end
    end

    assign seg_empty = (remaining == '0);
    assign word_last = (remaining <= lwc_seg_len_t'(lwc_bytes_per_word));

    // Capped at one full word
    always_comb begin
        if (word_last) begin
            word_size = remaining[2:0];
        end else begin
            word_size = lwc_size_t'(lwc_bytes_per_word);
        end
    end

endmodule

`default_nettype wire

/* verilog/lwc_control_fsm.sv */
// Instruction and segment control FSM
`timescale 1ns/100ps
`default_nettype none

module lwc_control_fsm (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lwc_pkg::lwc_word_t    buf_data,
    input  logic                 buf_valid,
    output logic                 buf_pop,
    output logic                 cnt_load,
    output logic                 cnt_step,
    input  logic                 seg_empty,
    input  logic                 word_last,
    output logic                 fmt_valid,
    input  logic                 fmt_ready,
    output lwc_pkg::lwc_do_sel_e do_sel,
    output lwc_pkg::lwc_opcode_e opcode
);

    import lwc_pkg::*;

    typedef enum logic [2:0] {
        st_inst,
        st_seg_hdr,
        st_out_hdr,
        st_data,
        st_status
    } state_e;

    state_e state;
    state_e state_next;
    state_e seg_done;
    logic   seg_last;

    // Where to go once the current segment is finished
    assign seg_done = seg_last ? st_status : st_seg_hdr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_inst;
            opcode <= op_enc;
            seg_last <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_inst && buf_valid) begin
                opcode <= lwc_opcode_e'(buf_data[lwc_word_w-1 -: 4]);
            end
            if (cnt_load) begin
                seg_last <= buf_data[lwc_last_bit];
            end
        end
    end

    always_comb begin
        state_next = state;
        buf_pop = 1'b0;
        cnt_load = 1'b0;
        cnt_step = 1'b0;
        fmt_valid = 1'b0;
        do_sel = sel_none;
        case (state)
            st_inst: begin
                if (buf_valid) begin
                    buf_pop = 1'b1;
                    state_next = st_seg_hdr;
                end
            end
            st_seg_hdr: begin
                // Header stays in the buffer for the output header
                if (buf_valid) begin
                    cnt_load = 1'b1;
                    state_next = st_out_hdr;
                end
            end
            st_out_hdr: begin
                do_sel = sel_out_hdr;
                fmt_valid = buf_valid;
                if (buf_valid && fmt_ready) begin
                    buf_pop = 1'b1;
                    state_next = seg_empty ? seg_done : st_data;
                end
            end
            st_data: begin
                do_sel = sel_data;
                fmt_valid = buf_valid;
                if (buf_valid && fmt_ready) begin
                    buf_pop = 1'b1;
                    cnt_step = 1'b1;
                    if (word_last) begin
                        state_next = seg_done;
                    end
                end
            end
            st_status: begin
                do_sel = sel_status;
                fmt_valid = 1'b1;
                if (fmt_ready) begin
                    state_next = st_inst;
                end
            end
            default: begin
                state_next = st_inst;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lwc_do_formatter.sv */
// DO word formatter
`timescale 1ns/100ps
`default_nettype none

module lwc_do_formatter (
    input  lwc_pkg::lwc_word_t    buf_data,
    input  lwc_pkg::lwc_do_sel_e do_sel,
    input  lwc_pkg::lwc_opcode_e opcode,
    input  lwc_pkg::lwc_size_t    word_size,
    input  logic                 word_last,
    output lwc_pkg::lwc_word_t    fmt_data,
    output logic                 fmt_last
);

    import lwc_pkg::*;

    lwc_word_t out_hdr;
    lwc_word_t data_mask;
    logic      eot;

    assign eot = buf_data[lwc_eot_bit];

    always_comb begin
        out_hdr = '0;
        out_hdr[lwc_seg_len_w-1:0] = buf_data[lwc_seg_len_w-1:0];
        out_hdr[lwc_eot_bit] = eot;
        case (opcode)
            op_dec: begin
                out_hdr[lwc_word_w-1 -: 4] = lwc_hdr_dec_code;
                out_hdr[lwc_last_bit] = eot;
            end
            default: begin
                out_hdr[lwc_word_w-1 -: 4] = lwc_hdr_enc_code;
            end
        endcase
    end

    // Keep the leading word_size bytes of a final word
    always_comb begin
        data_mask = '1;
        if (word_last) begin
            for (int i = 0; i < lwc_bytes_per_word; i++) begin
                if (i >= int'(word_size)) begin
                    data_mask[lwc_word_w-1-8*i -: 8] = 8'h00;
                end
            end
        end
    end

    always_comb begin
        fmt_data = '0;
        fmt_last = 1'b0;
        case (do_sel)
            sel_out_hdr: fmt_data = out_hdr;
            sel_data:    fmt_data = buf_data & data_mask;
            sel_status: begin
                fmt_data[lwc_word_w-1 -: 4] = lwc_status_ok_code;
                fmt_last = 1'b1;
            end
            default:     fmt_data = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/lwc_do_buffer.sv */
// DO output buffer
`timescale 1ns/100ps
`default_nettype none

module lwc_do_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  lwc_pkg::lwc_word_t fmt_data,
    input  logic              fmt_last,
    input  logic              fmt_valid,
    output logic              fmt_ready,
    output lwc_pkg::lwc_word_t do_data,
    output logic              do_valid,
    output logic              do_last,
    input  logic              do_ready
);

    logic take;

    // Refill in the same cycle the held word is drained
    assign fmt_ready = !do_valid || do_ready;
    assign take = fmt_valid && fmt_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            do_valid <= 1'b0;
            do_last <= 1'b0;
        end else if (take) begin
            do_valid <= 1'b1;
            do_last <= fmt_last;
        end else if (do_ready) begin
            do_valid <= 1'b0;
            do_last <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            do_data <= fmt_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/lwc_framer.sv */
// LWC public data framer
`timescale 1ns/100ps
`default_nettype none

module lwc_framer (
    input  logic              clk,
    input  logic              arst_n,
    input  lwc_pkg::lwc_word_t pdi_data,
    input  logic              pdi_valid,
    output logic              pdi_ready,
    output lwc_pkg::lwc_word_t do_data,
    output logic              do_valid,
    output logic              do_last,
    input  logic              do_ready
);

    import lwc_pkg::*;

    lwc_word_t   buf_data;
    logic        buf_valid;
    logic        buf_pop;
    logic        cnt_load;
    logic        cnt_step;
    logic        seg_empty;
    logic        word_last;
    lwc_size_t   word_size;
    logic        fmt_valid;
    logic        fmt_ready;
    lwc_word_t   fmt_data;
    logic        fmt_last;
    lwc_do_sel_e do_sel;
    lwc_opcode_e opcode;

    lwc_pdi_buffer pdi_buffer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .buf_data  (buf_data),
        .buf_valid (buf_valid),
        .buf_pop   (buf_pop)
    );

    lwc_segment_counter segment_counter_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .buf_data  (buf_data),
        .cnt_load  (cnt_load),
        .cnt_step  (cnt_step),
        .seg_empty (seg_empty),
        .word_last (word_last),
        .word_size (word_size)
    );

    lwc_control_fsm control_fsm_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .buf_data  (buf_data),
        .buf_valid (buf_valid),
        .buf_pop   (buf_pop),
        .cnt_load  (cnt_load),
        .cnt_step  (cnt_step),
        .seg_empty (seg_empty),
        .word_last (word_last),
        .fmt_valid (fmt_valid),
        .fmt_ready (fmt_ready),
        .do_sel    (do_sel),
        .opcode    (opcode)
    );

    lwc_do_formatter do_formatter_inst (
        .buf_data  (buf_data),
        .do_sel    (do_sel),
        .opcode    (opcode),
        .word_size (word_size),
        .word_last (word_last),
        .fmt_data  (fmt_data),
        .fmt_last  (fmt_last)
    );

    lwc_do_buffer do_buffer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .fmt_data  (fmt_data),
        .fmt_last  (fmt_last),
        .fmt_valid (fmt_valid),
        .fmt_ready (fmt_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_last   (do_last),
        .do_ready  (do_ready)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* verif/lwc_framer_assert.sv */
// DO handshake assertions
`timescale 1ns/100ps
`default_nettype none

module lwc_framer_assert (
    input logic               clk,
    input logic               arst_n,
    input lwc_pkg::lwc_word_t do_data,
    input logic               do_valid,
    input logic               do_last,
    input logic               do_ready
);

    import lwc_pkg::*;

    // Held word must not change under back-pressure
    property do_hold_p;
        @(posedge clk) disable iff (!arst_n)
        do_valid && !do_ready |=> do_valid && $stable(do_data) && $stable(do_last);
    endproperty

    do_hold_a: assert property (do_hold_p)
        else $error("DO word changed while stalled");

    do_last_valid_a: assert property (@(posedge clk) do_last |-> do_valid)
        else $error("do_last high without do_valid");

    do_reset_a: assert property (@(posedge clk) !arst_n |-> !do_valid)
        else $error("do_valid high during reset");

endmodule

`default_nettype wire

/* verif/lwc_framer_tb.sv */
// LWC framer testbench
`timescale 1ns/100ps
`default_nettype none

module lwc_framer_tb;

    import lwc_pkg::*;

    localparam int n_pdi = 19;
    localparam int n_exp = 19;
    localparam int timeout_cycles = 40 * (n_pdi + n_exp);

    // PDI words, three messages back to back
    localparam lwc_word_t pdi_table [n_pdi] = '{
        // enc, one 7-byte last segment with eot
        {op_enc, 28'h0}, 32'h0300_0007, 32'h1122_3344, 32'h5566_7788,
        // dec, 4-byte eot segment, then empty last segment
        {op_dec, 28'h0}, 32'h0200_0004, 32'hAABB_CCDD, 32'h0100_0000,
        // enc, segments of 8, 5 and 12 bytes
        {op_enc, 28'h0}, 32'h0000_0008, 32'h0102_0304, 32'h0506_0708,
        32'h0000_0005, 32'h090A_0B0C, 32'h0D0E_0F10,
        32'h0300_000C, 32'h2122_2324, 32'h2526_2728, 32'h292A_2B2C
    };

    // Expected DO words
    localparam lwc_word_t exp_data [n_exp] = '{
        32'h5200_0007, 32'h1122_3344, 32'h5566_7700, 32'hE000_0000,
        32'h4300_0004, 32'hAABB_CCDD, 32'h4000_0000, 32'hE000_0000,
        32'h5000_0008, 32'h0102_0304, 32'h0506_0708,
        32'h5000_0005, 32'h090A_0B0C, 32'h0D00_0000,
        32'h5200_000C, 32'h2122_2324, 32'h2526_2728, 32'h292A_2B2C, 32'hE000_0000
    };

    localparam logic exp_last [n_exp] = '{
        1'b0, 1'b0, 1'b0, 1'b1,
        1'b0, 1'b0, 1'b0, 1'b1,
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1
    };

    // Message each expected word belongs to
    localparam int exp_msg [n_exp] = '{
        0, 0, 0, 0,
        1, 1, 1, 1,
        2, 2, 2, 2, 2, 2, 2, 2, 2, 2, 2
    };

    logic      clk;
    logic      arst_n;
    lwc_word_t pdi_data;
    logic      pdi_valid;
    logic      pdi_ready;
    lwc_word_t do_data;
    logic      do_valid;
    logic      do_last;
    logic      do_ready;

    tb_clock_gen clock_gen_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    lwc_framer lwc_framer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .pdi_data  (pdi_data),
        .pdi_valid (pdi_valid),
        .pdi_ready (pdi_ready),
        .do_data   (do_data),
        .do_valid  (do_valid),
        .do_last   (do_last),
        .do_ready  (do_ready)
    );

    bind lwc_do_buffer lwc_framer_assert do_buffer_assert_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .do_data  (do_data),
        .do_valid (do_valid),
        .do_last  (do_last),
        .do_ready (do_ready)
    );

    function automatic string msg_name(input int m);
        case (m)
            0:       return "enc_7_byte";
            1:       return "dec_eot_empty_last";
            default: return "enc_three_segments";
        endcase
    endfunction

    task automatic check_word(input string name, input lwc_word_t exp, input lwc_word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s do_data expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Wrong DO data word");
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s do_last expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1, "Wrong do_last flag");
        end
    endtask

    // PDI driver with random idle cycles
    initial begin : drive_pdi
        int   idx;
        logic accepted;
        void'($urandom(72700));
        pdi_data = '0;
        pdi_valid = 1'b0;
        do_ready = 1'b0;
        idx = 0;
        wait (arst_n === 1'b1);
        @(posedge clk);
        while (idx < n_pdi) begin
            if (($urandom % 4) == 0) begin
                pdi_valid <= 1'b0;
            end else begin
                pdi_valid <= 1'b1;
                pdi_data <= pdi_table[idx];
            end
            @(negedge clk);
            accepted = pdi_valid && pdi_ready;
            @(posedge clk);
            if (accepted) begin
                idx++;
            end
        end
        pdi_valid <= 1'b0;
    end

    // Random DO back-pressure
    initial begin : drive_do_ready
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            do_ready <= ($urandom % 3) != 0;
        end
    end

    initial begin : collect_do
        int    n;
        logic  extra_seen;
        string name;
        n = 0;
        extra_seen = 1'b0;
        wait (arst_n === 1'b1);
        while (n < n_exp) begin
            @(negedge clk);
            if (do_valid && do_ready) begin
                name = $sformatf("%s word %0d", msg_name(exp_msg[n]), n);
                check_word(name, exp_data[n], do_data);
                check_last(name, exp_last[n], do_last);
                n++;
            end
        end
        // Nothing may follow the final status word
        repeat (8) begin
            @(negedge clk);
            if (do_valid) begin
                extra_seen = 1'b1;
            end
        end
        if (extra_seen) begin
            $display("Test failed");
            $fatal(1, "DO produced a word after the expected sequence");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("Test failed");
        $fatal(1, "Timeout after %0d cycles waiting for DO words", timeout_cycles);
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/lwc_pkg.sv
verilog/lwc_pdi_buffer.sv
verilog/lwc_segment_counter.sv
verilog/lwc_control_fsm.sv
verilog/lwc_do_formatter.sv
verilog/lwc_do_buffer.sv
verilog/lwc_framer.sv
verif/tb_clock_gen.sv
verif/lwc_framer_assert.sv
verif/lwc_framer_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the framer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module lwc_framer_tb -o sim_lwc_framer; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/sim_lwc_framer; then
    echo "Simulation failed"
    exit 1
fi

exit 0
